/* project.f */
logic/conv_pkg.sv
logic/line_ram.sv
logic/read_requester.sv
logic/operand_loader.sv
logic/exec_sequencer.sv
logic/mac_lane.sv
logic/result_fifo.sv
logic/write_requester.sv
logic/conv_engine.sv
sim/tb_mem_model.sv
sim/tb_conv_engine.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_conv_engine
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_conv_engine.sv */
// testbench for the convolution engine
// runs jobs against the memory model, checks every read and write request
// against a reference model and prints one line per test
module tb_conv_engine;
  timeunit 1ns;
  timeprecision 100ps;

  function automatic int lines_of(input int maps, input int outs);
    return maps + maps * outs + outs;
  endfunction

  // three small jobs, one full-size job and one 3x4 job
  localparam int TOTAL_LINES = 3 * lines_of(2, 3) + lines_of(16, 16) + lines_of(3, 4);
  localparam int MAX_CYCLES = 20 * TOTAL_LINES + 2000;

  logic clk;
  logic reset;
  logic start;
  conv_pkg::job_cfg_t cfg;
  logic random_mode;
  logic rd_req_en;
  conv_pkg::rd_req_t rd_req;
  logic rd_req_almostfull;
  logic rd_rsp_valid;
  conv_pkg::rd_rsp_t rd_rsp;
  logic wr_req_en;
  conv_pkg::wr_req_t wr_req;
  logic wr_req_almostfull;
  logic done;

  conv_pkg::job_cfg_t job;
  int rd_idx;
  int wr_idx;
  int errors;
  int tests_run;
  int tests_failed;
  int jobs_done;
  int cycles;
  logic rd_af_q;
  logic wr_af_q;

  conv_engine i_dut (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .cfg              (cfg),
    .rd_req_en        (rd_req_en),
    .rd_req           (rd_req),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_rsp_valid     (rd_rsp_valid),
    .rd_rsp           (rd_rsp),
    .wr_req_en        (wr_req_en),
    .wr_req           (wr_req),
    .wr_req_almostfull(wr_req_almostfull),
    .done             (done)
  );

  tb_mem_model i_mem (
    .clk              (clk),
    .reset            (reset),
    .random_mode      (random_mode),
    .rd_req_en        (rd_req_en),
    .rd_req           (rd_req),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_rsp_valid     (rd_rsp_valid),
    .rd_rsp           (rd_rsp),
    .wr_req_almostfull(wr_req_almostfull)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // result line o: sum over maps of image[m] times kernel[o*num_maps+m], per bin
  function automatic conv_pkg::out_line_t ref_line(input conv_pkg::job_cfg_t c, input int o);
    conv_pkg::out_line_t acc;
    conv_pkg::line_t img;
    conv_pkg::line_t ker;
    longint ar;
    longint ai;
    longint br;
    longint bi;
    longint pr;
    longint pi;
    acc = '0;
    for (int m = 0; m < c.num_maps; m++) begin
      img = i_mem.line_data(c.image_base + m);
      ker = i_mem.line_data(c.kernel_base + o * c.num_maps + m);
      for (int k = 0; k < conv_pkg::LANES; k++) begin
        ar = img[k].re;
        ai = img[k].im;
        br = ker[k].re;
        bi = ker[k].im;
        pr = ar * br - ai * bi;
        pi = ar * bi + ai * br;
        acc[k].re = acc[k].re + pr[31:0];
        acc[k].im = acc[k].im + pi[31:0];
      end
    end
    return acc;
  endfunction

  // back-pressure as the DUT saw it on the last rising edge
  always @(posedge clk) begin
    rd_af_q <= rd_req_almostfull;
    wr_af_q <= wr_req_almostfull;
  end

  // read requests: all image lines, then all kernel lines
  always @(negedge clk) begin
    int total;
    total = job.num_maps + job.num_maps * job.num_out;
    if (!reset && rd_req_en) begin
      if (rd_af_q) begin
        errors++;
        $display("read request issued under read back-pressure at %0t ns", $time);
      end
      if (rd_idx < job.num_maps) begin
        check("rd_req.addr", rd_req.addr, job.image_base + rd_idx);
        check("rd_req.tag", rd_req.tag, conv_pkg::TAG_IMAGE);
      end else if (rd_idx < total) begin
        check("rd_req.addr", rd_req.addr, job.kernel_base + (rd_idx - job.num_maps));
        check("rd_req.tag", rd_req.tag, conv_pkg::TAG_KERNEL);
      end else begin
        errors++;
        $display("read request to %0h beyond the job's lines at %0t ns", rd_req.addr, $time);
      end
      rd_idx++;
    end
  end

  // compare process for write requests
  always @(negedge clk) begin
    if (!reset && wr_req_en) begin
      if (wr_af_q) begin
        errors++;
        $display("write request issued under write back-pressure at %0t ns", $time);
      end
      check("done", done, 1'b0);
      if (wr_idx < job.num_out) begin
        check("wr_req.addr", wr_req.addr, job.dest_base + wr_idx);
        check("wr_req.data", wr_req.data, ref_line(job, wr_idx));
      end else begin
        errors++;
        $display("extra write request to %0h at %0t ns", wr_req.addr, $time);
      end
      wr_idx++;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic report(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  task automatic pulse_start(input conv_pkg::job_cfg_t c);
    @(negedge clk);
    cfg = c;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic run_job(input string name, input conv_pkg::job_cfg_t c,
                         input bit noisy, input bit busy_starts);
    int err0;
    conv_pkg::job_cfg_t other;
    err0 = errors;
    other = c;
    other.image_base = 32'h0bad_0000;
    other.num_maps = 5'd1;
    other.num_out = 5'd1;
    @(posedge clk);
    random_mode = noisy;
    job = c;
    rd_idx = 0;
    wr_idx = 0;
    if (jobs_done > 0) begin
      check("done", done, 1'b1);
    end
    pulse_start(c);
    check("done", done, 1'b0);
    if (busy_starts) begin
      // one start while reading, one while writing
      while (rd_idx < 4) @(posedge clk);
      pulse_start(other);
      cfg = c;
      while (wr_idx < 1) @(posedge clk);
      pulse_start(other);
      cfg = c;
    end
    while (!done) @(negedge clk);
    // late or extra writes would show up in this window
    repeat (20) @(posedge clk);
    check("write count", wr_idx, c.num_out);
    check("read count", rd_idx, c.num_maps + c.num_maps * c.num_out);
    check("done", done, 1'b1);
    jobs_done++;
    report(name, err0);
  endtask

  initial begin
    conv_pkg::job_cfg_t job_a;
    conv_pkg::job_cfg_t job_full;
    conv_pkg::job_cfg_t job_b;
    int err0;
    reset = 1'b1;
    start = 1'b0;
    cfg = '0;
    random_mode = 1'b0;
    job = '0;
    rd_idx = 0;
    wr_idx = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    jobs_done = 0;
    cycles = 0;
    job_a = '{image_base: 32'h100, kernel_base: 32'h200, dest_base: 32'h300,
              num_maps: 5'd2, num_out: 5'd3};
    job_full = '{image_base: 32'h1000_0000, kernel_base: 32'h1000_4000,
                 dest_base: 32'h5000, num_maps: 5'd16, num_out: 5'd16};
    job_b = '{image_base: 32'h2_0000, kernel_base: 32'h2_1000, dest_base: 32'h2_2000,
              num_maps: 5'd3, num_out: 5'd4};
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    err0 = errors;
    repeat (10) begin
      @(negedge clk);
      check("rd_req_en", rd_req_en, 1'b0);
      check("wr_req_en", wr_req_en, 1'b0);
      check("done", done, 1'b0);
    end
    report("idle_after_reset", err0);

    run_job("basic_2x3", job_a, 1'b0, 1'b0);
    run_job("backpressure_2x3", job_a, 1'b1, 1'b0);
    run_job("full_16x16", job_full, 1'b1, 1'b0);
    run_job("second_job_3x4", job_b, 1'b0, 1'b0);
    run_job("start_while_busy", job_a, 1'b0, 1'b1);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* sim/tb_mem_model.sv */
// shared line memory seen by the convolution engine testbench
// answers read requests in order after a random delay and, in random
// mode, drives both almost-full inputs from an LCG
module tb_mem_model (
  input  logic              clk,
  input  logic              reset,
  input  logic              random_mode,
  input  logic              rd_req_en,
  input  conv_pkg::rd_req_t rd_req,
  output logic              rd_req_almostfull,
  output logic              rd_rsp_valid,
  output conv_pkg::rd_rsp_t rd_rsp,
  output logic              wr_req_almostfull
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED = 32'd73;

  conv_pkg::rd_req_t req_q[$];
  int due_q[$];
  int cycle;
  logic [31:0] rnd;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // contents of one line, mixed from the full address
  // lines with address bit 28 set hold only extreme samples
  function automatic conv_pkg::line_t line_data(input logic [31:0] addr);
    conv_pkg::line_t line;
    logic [31:0] s;
    s = lcg_next(addr ^ SEED) ^ {addr[15:0], addr[31:16]};
    for (int k = 0; k < conv_pkg::LANES; k++) begin
      s = lcg_next(s);
      line[k].re = addr[28] ? (s[31] ? 16'h7fff : 16'h8000) : s[31:16];
      s = lcg_next(s);
      line[k].im = addr[28] ? (s[30] ? 16'h7fff : 16'h8000) : s[31:16];
    end
    return line;
  endfunction

  initial begin
    rd_req_almostfull = 1'b0;
    wr_req_almostfull = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp = '0;
    rnd = SEED;
    cycle = 0;
  end

  always @(negedge clk) begin
    conv_pkg::rd_req_t head;
    if (reset) begin
      req_q.delete();
      due_q.delete();
      cycle = 0;
      rnd = SEED;
      rd_rsp_valid = 1'b0;
      rd_req_almostfull = 1'b0;
      wr_req_almostfull = 1'b0;
    end else begin
      cycle = cycle + 1;
      rnd = lcg_next(rnd);
      if (rd_req_en) begin
        req_q.push_back(rd_req);
        due_q.push_back(cycle + 1 + (random_mode ? int'(rnd[17:16]) : 0));
      end
      // the queue keeps responses in request order
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        head = req_q.pop_front();
        void'(due_q.pop_front());
        rd_rsp_valid = 1'b1;
        rd_rsp.tag = head.tag;
        rd_rsp.data = line_data(head.addr);
      end else begin
        rd_rsp_valid = 1'b0;
      end
      rd_req_almostfull = random_mode && rnd[21];
      wr_req_almostfull = random_mode && rnd[25];
    end
  end

endmodule

/* logic/conv_engine.sv */
// frequency-domain convolution engine, top level
// loads image and kernel lines of a job, multiplies them bin by bin,
// sums over input maps and writes one line per output map
module conv_engine (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  conv_pkg::job_cfg_t cfg,
  output logic               rd_req_en,
  output conv_pkg::rd_req_t  rd_req,
  input  logic               rd_req_almostfull,
  input  logic               rd_rsp_valid,
  input  conv_pkg::rd_rsp_t  rd_rsp,
  output logic               wr_req_en,
  output conv_pkg::wr_req_t  wr_req,
  input  logic               wr_req_almostfull,
  output logic               done
);

  logic busy;
  logic job_start;
  conv_pkg::job_cfg_t cfg_q;
  conv_pkg::job_cfg_t job_cfg;

  logic image_we;
  logic kernel_we;
  logic [conv_pkg::IMAGE_AW-1:0] image_waddr;
  logic [conv_pkg::IMAGE_AW-1:0] image_raddr;
  logic [conv_pkg::KERNEL_AW-1:0] kernel_waddr;
  logic [conv_pkg::KERNEL_AW-1:0] kernel_raddr;
  logic operands_ready;
  conv_pkg::line_t image_line;
  conv_pkg::line_t kernel_line;
  conv_pkg::mac_ctrl_t mac_ctrl;

  conv_pkg::out_line_t result_line;
  logic [conv_pkg::LANES-1:0] lane_valid;
  conv_pkg::out_line_t fifo_data;
  logic fifo_pop;
  logic fifo_empty;
  logic fifo_almost_full;

  // a start is taken when idle or once the previous job is done
  assign job_start = start && (!busy || done);
  // the requester sees the new job on the accepting edge itself
  assign job_cfg = job_start ? cfg : cfg_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else begin
      busy <= job_start || (busy && !done);
    end
  end

  always_ff @(posedge clk) begin
    if (job_start) begin
      cfg_q <= cfg;
    end
  end

  read_requester i_read_requester (
    .clk              (clk),
    .reset            (reset),
    .job_start        (job_start),
    .cfg              (job_cfg),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_req_en        (rd_req_en),
    .rd_req           (rd_req)
  );

  operand_loader i_operand_loader (
    .clk           (clk),
    .reset         (reset),
    .job_start     (job_start),
    .num_maps      (cfg_q.num_maps),
    .num_out       (cfg_q.num_out),
    .rd_rsp_valid  (rd_rsp_valid),
    .rd_rsp        (rd_rsp),
    .image_we      (image_we),
    .image_waddr   (image_waddr),
    .kernel_we     (kernel_we),
    .kernel_waddr  (kernel_waddr),
    .operands_ready(operands_ready)
  );

  line_ram #(
    .payload_t(conv_pkg::line_t),
    .DEPTH    (conv_pkg::IMAGE_DEPTH)
  ) i_image_ram (
    .clk  (clk),
    .we   (image_we),
    .waddr(image_waddr),
    .wdata(rd_rsp.data),
    .raddr(image_raddr),
    .rdata(image_line)
  );

  line_ram #(
    .payload_t(conv_pkg::line_t),
    .DEPTH    (conv_pkg::KERNEL_DEPTH)
  ) i_kernel_ram (
    .clk  (clk),
    .we   (kernel_we),
    .waddr(kernel_waddr),
    .wdata(rd_rsp.data),
    .raddr(kernel_raddr),
    .rdata(kernel_line)
  );

  exec_sequencer i_exec_sequencer (
    .clk             (clk),
    .reset           (reset),
    .job_start       (job_start),
    .operands_ready  (operands_ready),
    .num_maps        (cfg_q.num_maps),
    .num_out         (cfg_q.num_out),
    .fifo_almost_full(fifo_almost_full),
    .image_raddr     (image_raddr),
    .kernel_raddr    (kernel_raddr),
    .mac_ctrl        (mac_ctrl)
  );

  // lanes run in lockstep, lane 0 speaks for all
  for (genvar l = 0; l < conv_pkg::LANES; l++) begin : g_lane
    mac_lane i_mac_lane (
      .clk         (clk),
      .reset       (reset),
      .mac_ctrl    (mac_ctrl),
      .image_bin   (image_line[l]),
      .kernel_bin  (kernel_line[l]),
      .result      (result_line[l]),
      .result_valid(lane_valid[l])
    );
  end

  result_fifo i_result_fifo (
    .clk        (clk),
    .reset      (reset),
    .push       (lane_valid[0]),
    .push_data  (result_line),
    .pop        (fifo_pop),
    .pop_data   (fifo_data),
    .empty      (fifo_empty),
    .almost_full(fifo_almost_full)
  );

  write_requester i_write_requester (
    .clk              (clk),
    .reset            (reset),
    .job_start        (job_start),
    .dest_base        (cfg_q.dest_base),
    .num_out          (cfg_q.num_out),
    .empty            (fifo_empty),
    .pop_data         (fifo_data),
    .wr_req_almostfull(wr_req_almostfull),
    .pop              (fifo_pop),
    .wr_req_en        (wr_req_en),
    .wr_req           (wr_req),
    .done             (done)
  );

endmodule

/* logic/write_requester.sv */
// turns result lines into write requests at consecutive addresses
// done rises after the last line of the job has been sent
module write_requester (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       job_start,
  input  logic [conv_pkg::ADDR_W-1:0] dest_base,
  input  logic [conv_pkg::NUM_W-1:0] num_out,
  input  logic                       empty,
  input  conv_pkg::out_line_t        pop_data,
  input  logic                       wr_req_almostfull,
  output logic                       pop,
  output logic                       wr_req_en,
  output conv_pkg::wr_req_t          wr_req,
  output logic                       done
);

  logic [conv_pkg::NUM_W-1:0] wr_cnt;

  assign pop = !wr_req_almostfull && !empty;

  always_ff @(posedge clk) begin
    if (pop) begin
      wr_req.addr <= dest_base + conv_pkg::ADDR_W'(wr_cnt);
      wr_req.data <= pop_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_req_en <= 1'b0;
      wr_cnt <= '0;
      done <= 1'b0;
    end else begin
      wr_req_en <= pop;
      if (job_start) begin
        wr_cnt <= '0;
        done <= 1'b0;
      end else begin
        if (pop) begin
          wr_cnt <= wr_cnt + 1'b1;
        end
        // count already includes the line going out now
        if (wr_req_en && wr_cnt == num_out) begin
          done <= 1'b1;
        end
      end
    end
  end

endmodule

/* logic/result_fifo.sv */
// synchronous FIFO of finished result lines
// the head line is visible on pop_data before the pop
module result_fifo (
  input  logic                clk,
  input  logic                reset,
  input  logic                push,
  input  conv_pkg::out_line_t push_data,
  input  logic                pop,
  output conv_pkg::out_line_t pop_data,
  output logic                empty,
  output logic                almost_full
);

  conv_pkg::out_line_t mem [conv_pkg::FIFO_DEPTH];
  logic [conv_pkg::FIFO_AW-1:0] wr_ptr;
  logic [conv_pkg::FIFO_AW-1:0] rd_ptr;
  logic [conv_pkg::FIFO_AW:0] count;

  assign pop_data = mem[rd_ptr];
  assign empty = (count == '0);
  assign almost_full = (count >= (conv_pkg::FIFO_AW + 1)'(conv_pkg::FIFO_AFULL));

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* logic/mac_lane.sv */
// one bin of the datapath: complex multiply, then accumulate
// the accumulator loads on first, adds otherwise, and shows the sum on last
module mac_lane (
  input  logic                clk,
  input  logic                reset,
  input  conv_pkg::mac_ctrl_t mac_ctrl,
  input  conv_pkg::complex_t  image_bin,
  input  conv_pkg::complex_t  kernel_bin,
  output conv_pkg::acc_t      result,
  output logic                result_valid
);

  logic signed [conv_pkg::ACC_W-1:0] ar;
  logic signed [conv_pkg::ACC_W-1:0] ai;
  logic signed [conv_pkg::ACC_W-1:0] br;
  logic signed [conv_pkg::ACC_W-1:0] bi;
  conv_pkg::acc_t prod;
  conv_pkg::mac_ctrl_t ctrl_q;

  // sign-extend, all sums wrap at ACC_W
  assign ar = image_bin.re;
  assign ai = image_bin.im;
  assign br = kernel_bin.re;
  assign bi = kernel_bin.im;

  always_ff @(posedge clk) begin
    prod.re <= ar * br - ai * bi;
    prod.im <= ar * bi + ai * br;
    if (ctrl_q.valid) begin
      if (ctrl_q.first) begin
        result <= prod;
      end else begin
        result.re <= result.re + prod.re;
        result.im <= result.im + prod.im;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_q <= '0;
      result_valid <= 1'b0;
    end else begin
      ctrl_q <= mac_ctrl;
      result_valid <= ctrl_q.valid && ctrl_q.last;
    end
  end

endmodule

/* logic/exec_sequencer.sv */
// walks the output maps and, inside each, the input maps of a job
// one step per cycle, a group of num_maps steps per output line
// a group only starts while the result FIFO has room
module exec_sequencer (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           job_start,
  input  logic                           operands_ready,
  input  logic [conv_pkg::NUM_W-1:0]     num_maps,
  input  logic [conv_pkg::NUM_W-1:0]     num_out,
  input  logic                           fifo_almost_full,
  output logic [conv_pkg::IMAGE_AW-1:0]  image_raddr,
  output logic [conv_pkg::KERNEL_AW-1:0] kernel_raddr,
  output conv_pkg::mac_ctrl_t            mac_ctrl
);

  logic running;
  logic in_group;
  logic [conv_pkg::NUM_W-1:0] map_cnt;
  logic [conv_pkg::NUM_W-1:0] out_cnt;
  logic [conv_pkg::KERNEL_AW-1:0] kaddr;
  logic issue;
  logic step_first;
  logic step_last;
  conv_pkg::mac_ctrl_t step_q;

  // never pause inside a group
  assign issue = running && (in_group || (operands_ready && !fifo_almost_full));
  assign step_first = (map_cnt == '0);
  assign step_last = (map_cnt == num_maps - 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      in_group <= 1'b0;
      map_cnt <= '0;
      out_cnt <= '0;
      kaddr <= '0;
      step_q <= '0;
      mac_ctrl <= '0;
    end else begin
      step_q.valid <= issue;
      step_q.first <= issue && step_first;
      step_q.last <= issue && step_last;
      // one more stage so the controls line up with the RAM data
      mac_ctrl <= step_q;
      if (job_start) begin
        running <= 1'b1;
        in_group <= 1'b0;
        map_cnt <= '0;
        out_cnt <= '0;
        kaddr <= '0;
      end else if (issue) begin
        kaddr <= kaddr + 1'b1;
        in_group <= !step_last;
        if (step_last) begin
          map_cnt <= '0;
          out_cnt <= out_cnt + 1'b1;
          if (out_cnt == num_out - 1'b1) begin
            running <= 1'b0;
          end
        end else begin
          map_cnt <= map_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      image_raddr <= map_cnt[conv_pkg::IMAGE_AW-1:0];
      kernel_raddr <= kaddr;
    end
  end

endmodule

/* logic/operand_loader.sv */
// steers read responses into the image and kernel RAMs by tag
// operands_ready rises once every line of the job is stored and holds
// until the next start
module operand_loader (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           job_start,
  input  logic [conv_pkg::NUM_W-1:0]     num_maps,
  input  logic [conv_pkg::NUM_W-1:0]     num_out,
  input  logic                           rd_rsp_valid,
  input  conv_pkg::rd_rsp_t              rd_rsp,
  output logic                           image_we,
  output logic [conv_pkg::IMAGE_AW-1:0]  image_waddr,
  output logic                           kernel_we,
  output logic [conv_pkg::KERNEL_AW-1:0] kernel_waddr,
  output logic                           operands_ready
);

  logic [conv_pkg::NUM_W-1:0] image_cnt;
  logic [conv_pkg::KCNT_W-1:0] kernel_cnt;
  logic [conv_pkg::KCNT_W-1:0] kernel_total;
  logic all_in;

  // responses come back in order, so a running count is the RAM address
  assign image_we = rd_rsp_valid && (rd_rsp.tag == conv_pkg::TAG_IMAGE);
  assign kernel_we = rd_rsp_valid && (rd_rsp.tag == conv_pkg::TAG_KERNEL);
  assign image_waddr = image_cnt[conv_pkg::IMAGE_AW-1:0];
  assign kernel_waddr = kernel_cnt[conv_pkg::KERNEL_AW-1:0];

  assign kernel_total = num_maps * num_out;
  assign all_in = rd_rsp_valid
                  && (image_cnt + conv_pkg::NUM_W'(image_we) == num_maps)
                  && (kernel_cnt + conv_pkg::KCNT_W'(kernel_we) == kernel_total);

  always_ff @(posedge clk) begin
    if (reset || job_start) begin
      image_cnt <= '0;
      kernel_cnt <= '0;
      operands_ready <= 1'b0;
    end else begin
      if (image_we) begin
        image_cnt <= image_cnt + 1'b1;
      end
      if (kernel_we) begin
        kernel_cnt <= kernel_cnt + 1'b1;
      end
      if (all_in) begin
        operands_ready <= 1'b1;
      end
    end
  end

endmodule

/* logic/read_requester.sv */
// read request generator of the convolution engine
// sends all image lines of a job, then all kernel lines, one per cycle
// and stops after any edge that sampled read back-pressure
module read_requester (
  input  logic               clk,
  input  logic               reset,
  input  logic               job_start,
  input  conv_pkg::job_cfg_t cfg,
  input  logic               rd_req_almostfull,
  output logic               rd_req_en,
  output conv_pkg::rd_req_t  rd_req
);

  typedef enum logic [1:0] {RD_IDLE, RD_IMAGE, RD_KERNEL} rd_state_e;

  rd_state_e state;
  rd_state_e cur_state;
  logic [conv_pkg::ADDR_W-1:0] addr_q;
  logic [conv_pkg::ADDR_W-1:0] cur_addr;
  logic [conv_pkg::KCNT_W-1:0] line_cnt;
  logic [conv_pkg::KCNT_W-1:0] cur_cnt;
  logic [conv_pkg::KCNT_W-1:0] last_cnt;
  logic issue;
  logic phase_end;

  // a start counts as image line 0, so the first read leaves on that edge
  always_comb begin
    if (job_start) begin
      cur_state = RD_IMAGE;
      cur_addr = cfg.image_base;
      cur_cnt = '0;
    end else begin
      cur_state = state;
      cur_addr = addr_q;
      cur_cnt = line_cnt;
    end
    if (cur_state == RD_KERNEL) begin
      last_cnt = cfg.num_maps * cfg.num_out - 1'b1;
    end else begin
      last_cnt = conv_pkg::KCNT_W'(cfg.num_maps) - 1'b1;
    end
  end

  assign issue = (cur_state != RD_IDLE) && !rd_req_almostfull;
  assign phase_end = issue && (cur_cnt == last_cnt);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= RD_IDLE;
      rd_req_en <= 1'b0;
      line_cnt <= '0;
    end else begin
      rd_req_en <= issue;
      state <= cur_state;
      line_cnt <= cur_cnt;
      if (phase_end) begin
        line_cnt <= '0;
        state <= (cur_state == RD_IMAGE) ? RD_KERNEL : RD_IDLE;
      end else if (issue) begin
        line_cnt <= cur_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    addr_q <= cur_addr;
    if (issue) begin
      rd_req.addr <= cur_addr;
      rd_req.tag <= (cur_state == RD_KERNEL) ? conv_pkg::TAG_KERNEL : conv_pkg::TAG_IMAGE;
      // kernel lines start at their own base
      addr_q <= (phase_end && cur_state == RD_IMAGE) ? cfg.kernel_base : cur_addr + 1'b1;
    end
  end

endmodule

/* logic/line_ram.sv */
// simple dual-port RAM, one write port and one registered read port
// the payload type is set per instance
module line_ram #(
  parameter type payload_t = logic,
  parameter int  DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  payload_t                 wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output payload_t                 rdata
);

  payload_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

/* logic/conv_pkg.sv */
// sizes, job limits and bus structs of the convolution engine
// shared by the RTL and the testbench through scoped names
package conv_pkg;

  localparam int LANES = 4;
  localparam int SAMPLE_W = 16;
  localparam int ACC_W = 32;
  localparam int ADDR_W = 32;

  // job limits, a job fits the local RAMs in one load
  localparam int MAX_MAPS = 16;
  localparam int MAX_OUT = 16;
  localparam int NUM_W = 5;
  localparam int KCNT_W = 2 * NUM_W;

  localparam int IMAGE_DEPTH = MAX_MAPS;
  localparam int KERNEL_DEPTH = MAX_MAPS * MAX_OUT;
  localparam int IMAGE_AW = $clog2(IMAGE_DEPTH);
  localparam int KERNEL_AW = $clog2(KERNEL_DEPTH);

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);
  localparam int FIFO_AFULL = FIFO_DEPTH - 4;

  // real part sits in the low half
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] im;
    logic signed [SAMPLE_W-1:0] re;
  } complex_t;

  typedef struct packed {
    logic signed [ACC_W-1:0] im;
    logic signed [ACC_W-1:0] re;
  } acc_t;

  typedef complex_t [LANES-1:0] line_t;
  typedef acc_t [LANES-1:0] out_line_t;

  typedef struct packed {
    logic [ADDR_W-1:0] image_base;
    logic [ADDR_W-1:0] kernel_base;
    logic [ADDR_W-1:0] dest_base;
    logic [NUM_W-1:0]  num_maps;
    logic [NUM_W-1:0]  num_out;
  } job_cfg_t;

  typedef enum logic {
    TAG_IMAGE  = 1'b0,
    TAG_KERNEL = 1'b1
  } rd_tag_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    rd_tag_e           tag;
  } rd_req_t;

  typedef struct packed {
    rd_tag_e tag;
    line_t   data;
  } rd_rsp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    out_line_t         data;
  } wr_req_t;

  typedef struct packed {
    logic valid;
    logic first;
    logic last;
  } mac_ctrl_t;

endpackage
